/* design/blockfall_pkg.sv */
`default_nettype none

package blockfall_pkg;

  localparam int COLS = 8; // board width, sets the row word

  typedef logic [2:0] cell_t;        // 0 is empty
  typedef cell_t [COLS-1:0] row_t;   // one board row, one ram word

  typedef enum logic [1:0] {PIECE_O, PIECE_I, PIECE_T} piece_e;

  typedef enum logic [2:0] {
    MOVE_SPAWN,
    MOVE_LEFT,
    MOVE_RIGHT,
    MOVE_ROR,   // rot + 1
    MOVE_ROL,   // rot - 1
    MOVE_DOWN
  } move_e;

  // kind sits above op to match the cmd register layout
  typedef struct packed {
    piece_e kind;
    move_e  op;
  } cmd_t;

  typedef struct packed {
    logic              valid;
    piece_e            kind;
    logic [1:0]        rot;
    logic signed [3:0] x;
    logic signed [4:0] y;
  } piece_t;

  typedef struct packed {
    logic       req;
    logic       we;
    logic [4:0] addr;
    row_t       wdata;
  } grid_req_t;

  typedef struct packed {
    logic rvalid;
    row_t rdata;
  } grid_rsp_t;

  //////////////////////////////
  // shape table, offsets in a 4x4 box

  typedef struct packed {
    logic [1:0] dx;
    logic [1:0] dy;
  } offs_t;

  typedef offs_t [3:0] shape_t;

  function automatic shape_t shape_cells(piece_e kind, logic [1:0] rot);
    shape_t s;
    case (kind)
      PIECE_I: s = rot[0] ? {2'd2, 2'd0, 2'd2, 2'd1, 2'd2, 2'd2, 2'd2, 2'd3}
                          : {2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1, 2'd3, 2'd1};
      PIECE_T: begin
        case (rot)
          2'd0:    s = {2'd1, 2'd0, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1};
          2'd1:    s = {2'd1, 2'd0, 2'd1, 2'd1, 2'd2, 2'd1, 2'd1, 2'd2};
          2'd2:    s = {2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1, 2'd1, 2'd2};
          default: s = {2'd1, 2'd0, 2'd0, 2'd1, 2'd1, 2'd1, 2'd1, 2'd2};
        endcase
      end
      default: s = {2'd1, 2'd0, 2'd2, 2'd0, 2'd1, 2'd1, 2'd2, 2'd1}; // O, no rotation
    endcase
    return s;
  endfunction

  function automatic cell_t piece_color(piece_e kind);
    return 3'(kind) + 3'd1;
  endfunction

endpackage

`default_nettype wire

/* design/grid_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module grid_ram #(
  parameter int ROWS = 16
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  blockfall_pkg::grid_req_t req_i,
  output blockfall_pkg::grid_rsp_t rsp_o,
  output logic                    ready_o   // low while clearing
);
  import blockfall_pkg::*;

  localparam int AW = $clog2(ROWS);

  row_t          mem_q [ROWS];
  logic [AW-1:0] clr_ptr_q;
  logic          clearing_q;
  logic          rvalid_q;
  row_t          rdata_q;

  assign ready_o = !clearing_q;
  assign rsp_o   = '{rvalid: rvalid_q, rdata: rdata_q};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      clearing_q <= 1'b1;
      clr_ptr_q  <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      rvalid_q <= req_i.req && !req_i.we && !clearing_q;
      if (clearing_q) begin
        clr_ptr_q <= clr_ptr_q + 1'b1;
        if (clr_ptr_q == AW'(ROWS - 1)) clearing_q <= 1'b0; // last row wiped
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (clearing_q) mem_q[clr_ptr_q] <= '0;
    else if (req_i.req && req_i.we) mem_q[req_i.addr[AW-1:0]] <= req_i.wdata;
    if (req_i.req && !req_i.we) rdata_q <= mem_q[req_i.addr[AW-1:0]];
  end

endmodule

`default_nettype wire

/* design/grid_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module grid_arbiter (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  blockfall_pkg::grid_req_t clr_req_i,
  input  blockfall_pkg::grid_req_t trk_req_i,
  input  blockfall_pkg::grid_req_t host_req_i,
  output logic                     clr_gnt_o,
  output logic                     trk_gnt_o,
  output logic                     host_gnt_o,
  output blockfall_pkg::grid_req_t mem_req_o,
  input  logic                     mem_ready_i
);

  typedef enum logic [1:0] {OWN_NONE, OWN_CLR, OWN_TRK, OWN_HOST} owner_e;

  owner_e owner_q, owner_d;

  always_comb begin
    owner_d = owner_q;
    // owner lets go by dropping req
    case (owner_q)
      OWN_CLR:  if (!clr_req_i.req) owner_d = OWN_NONE;
      OWN_TRK:  if (!trk_req_i.req) owner_d = OWN_NONE;
      OWN_HOST: if (!host_req_i.req) owner_d = OWN_NONE;
      default:  ;
    endcase
    if (owner_d == OWN_NONE && mem_ready_i) begin
      if (clr_req_i.req)       owner_d = OWN_CLR;  // clearer first
      else if (trk_req_i.req)  owner_d = OWN_TRK;
      else if (host_req_i.req) owner_d = OWN_HOST;
    end
  end

  assign clr_gnt_o  = (owner_d == OWN_CLR);
  assign trk_gnt_o  = (owner_d == OWN_TRK);
  assign host_gnt_o = (owner_d == OWN_HOST);

  always_comb begin
    case (owner_d)
      OWN_CLR:  mem_req_o = clr_req_i;
      OWN_TRK:  mem_req_o = trk_req_i;
      OWN_HOST: mem_req_o = host_req_i;
      default:  mem_req_o = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) owner_q <= OWN_NONE;
    else         owner_q <= owner_d;
  end

endmodule

`default_nettype wire

/* design/piece_tracker.sv */
`timescale 1ns/100ps
`default_nettype none

module piece_tracker #(
  parameter int ROWS = 16
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     cmd_valid_i,
  input  blockfall_pkg::cmd_t      cmd_i,
  output logic                     busy_o,
  output logic                     last_ok_o,
  output logic                     game_over_o,
  output blockfall_pkg::piece_t    piece_o,
  output blockfall_pkg::grid_req_t grid_req_o,
  input  logic                     grid_gnt_i,
  input  blockfall_pkg::grid_rsp_t grid_rsp_i,
  output logic                     clear_start_o,
  input  logic                     clear_done_i
);
  import blockfall_pkg::*;

  typedef enum logic [2:0] {IDLE, CHECK, LOCK_RD, LOCK_WR, CLEAR_WAIT} trk_state_e;

  trk_state_e state_q;
  cmd_t       cmd_q;
  piece_t     piece_q, cand, chk;
  shape_t     shp;
  logic       busy_q, last_ok_q, game_over_q, wait_q;
  logic [2:0] idx_q;       // box row 0..3, 4 = all rows done
  logic       pre_bad, col_bad, row_used, row_bad, blocked, reject, rd_back;
  int         row_abs;
  row_t       merged, row_buf_q;

  assign busy_o      = busy_q;
  assign last_ok_o   = last_ok_q;
  assign game_over_o = game_over_q;
  assign piece_o     = piece_q;

  //////////////////////////////
  // candidate piece

  always_comb begin
    cand    = piece_q;
    pre_bad = game_over_q || !piece_q.valid;
    case (cmd_q.op)
      MOVE_SPAWN: begin
        cand.valid = 1'b1;
        cand.kind  = cmd_q.kind;
        cand.rot   = 2'd0;
        cand.x     = 4'sd2;
        cand.y     = 5'sd0;
        pre_bad    = game_over_q || piece_q.valid ||
                     !(cmd_q.kind inside {PIECE_O, PIECE_I, PIECE_T});
      end
      MOVE_LEFT:  cand.x   = piece_q.x - 4'sd1;
      MOVE_RIGHT: cand.x   = piece_q.x + 4'sd1;
      MOVE_ROR:   cand.rot = piece_q.rot + 2'd1;
      MOVE_ROL:   cand.rot = piece_q.rot - 2'd1;
      MOVE_DOWN:  cand.y   = piece_q.y + 5'sd1;
      default:    pre_bad  = 1'b1; // unused opcodes
    endcase
  end

  //////////////////////////////
  // cells of the current box row

  always_comb begin
    int cx;
    chk      = (state_q == CHECK) ? cand : piece_q; // lock works on the live piece
    shp      = shape_cells(chk.kind, chk.rot);
    row_abs  = int'(chk.y) + int'(idx_q);
    row_bad  = (row_abs < 0) || (row_abs >= ROWS);
    col_bad  = 1'b0;
    row_used = 1'b0;
    blocked  = 1'b0;
    merged   = grid_rsp_i.rdata;
    for (int i = 0; i < 4; i++) begin
      cx = int'(chk.x) + int'(shp[i].dx);
      if (cx < 0 || cx >= COLS) col_bad = 1'b1;
      else if (int'(shp[i].dy) == int'(idx_q)) begin
        row_used = 1'b1;
        if (grid_rsp_i.rdata[cx] != '0) blocked = 1'b1;
        merged[cx] = piece_color(chk.kind);
      end
    end
  end

  assign rd_back = wait_q && grid_gnt_i && grid_rsp_i.rvalid; // our row is back
  assign reject  = pre_bad || col_bad || (row_used && row_bad) || (rd_back && blocked);

  always_comb begin
    grid_req_o      = '0;
    grid_req_o.addr = 5'(row_abs);
    case (state_q)
      CHECK:   grid_req_o.req = !(pre_bad || col_bad || row_bad) && idx_q != 3'd4 && row_used;
      LOCK_RD: grid_req_o.req = idx_q != 3'd4 && row_used;
      LOCK_WR: begin
        grid_req_o.req   = 1'b1; // req stays up from the read, so no one cuts in
        grid_req_o.we    = 1'b1;
        grid_req_o.wdata = row_buf_q;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q       <= IDLE;
      piece_q       <= '0;
      busy_q        <= 1'b0;
      last_ok_q     <= 1'b0;
      game_over_q   <= 1'b0;
      wait_q        <= 1'b0;
      idx_q         <= '0;
      clear_start_o <= 1'b0;
    end else begin
      clear_start_o <= 1'b0;
      case (state_q)
        IDLE: if (cmd_valid_i) begin
          busy_q  <= 1'b1;
          idx_q   <= '0;
          wait_q  <= 1'b0;
          state_q <= CHECK;
        end
        CHECK: begin
          if (reject) begin
            last_ok_q <= 1'b0;
            wait_q    <= 1'b0;
            idx_q     <= '0;
            if (!pre_bad && cmd_q.op == MOVE_DOWN) state_q <= LOCK_RD; // landed
            else begin
              if (!pre_bad && cmd_q.op == MOVE_SPAWN) game_over_q <= 1'b1;
              busy_q  <= 1'b0;
              state_q <= IDLE;
            end
          end else if (idx_q == 3'd4) begin
            piece_q   <= cand;
            last_ok_q <= 1'b1;
            busy_q    <= 1'b0;
            state_q   <= IDLE;
          end else if (!row_used) idx_q <= idx_q + 3'd1;
          else if (!wait_q) wait_q <= grid_gnt_i;
          else if (rd_back) begin
            wait_q <= 1'b0;
            idx_q  <= idx_q + 3'd1;
          end
        end
        LOCK_RD: begin
          if (idx_q == 3'd4) begin
            piece_q.valid <= 1'b0;
            clear_start_o <= 1'b1;
            state_q       <= CLEAR_WAIT;
          end else if (!row_used) idx_q <= idx_q + 3'd1;
          else if (!wait_q) wait_q <= grid_gnt_i;
          else if (rd_back) begin
            wait_q  <= 1'b0;
            state_q <= LOCK_WR;
          end
        end
        LOCK_WR: if (grid_gnt_i) begin
          idx_q   <= idx_q + 3'd1;
          state_q <= LOCK_RD;
        end
        default: if (clear_done_i) begin // CLEAR_WAIT
          busy_q  <= 1'b0;
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && cmd_valid_i) cmd_q <= cmd_i;
    if (state_q == LOCK_RD && rd_back) row_buf_q <= merged;
  end

endmodule

`default_nettype wire

/* design/line_clearer.sv */
`timescale 1ns/100ps
`default_nettype none

module line_clearer #(
  parameter int ROWS = 16
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     start_i,
  output blockfall_pkg::grid_req_t grid_req_o,
  input  logic                     grid_gnt_i,
  input  blockfall_pkg::grid_rsp_t grid_rsp_i,
  output logic                     done_o,
  output logic [2:0]               lines_o
);
  import blockfall_pkg::*;

  typedef enum logic [2:0] {CLR_IDLE, CLR_RD, CLR_WAIT, CLR_WR, CLR_FILL} clr_state_e;

  clr_state_e        state_q;
  logic signed [5:0] rd_ptr_q, wr_ptr_q; // go negative past the top row
  logic [2:0]        found_q;
  logic              row_full, rd_back;
  row_t              row_q;

  assign rd_back = grid_gnt_i && grid_rsp_i.rvalid;

  always_comb begin
    row_full = 1'b1;
    for (int c = 0; c < COLS; c++)
      if (grid_rsp_i.rdata[c] == '0) row_full = 1'b0;
  end

  always_comb begin
    grid_req_o = '0;
    case (state_q)
      CLR_RD, CLR_WAIT: begin
        grid_req_o.req  = !rd_ptr_q[5];
        grid_req_o.addr = rd_ptr_q[4:0];
      end
      CLR_WR, CLR_FILL: begin
        grid_req_o.req   = !wr_ptr_q[5];
        grid_req_o.we    = 1'b1;
        grid_req_o.addr  = wr_ptr_q[4:0];
        grid_req_o.wdata = (state_q == CLR_WR) ? row_q : '0; // zeros at the top
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= CLR_IDLE;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      found_q  <= '0;
      done_o   <= 1'b0;
      lines_o  <= '0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        CLR_IDLE: if (start_i) begin
          rd_ptr_q <= 6'(ROWS - 1);
          wr_ptr_q <= 6'(ROWS - 1);
          found_q  <= '0;
          state_q  <= CLR_RD;
        end
        CLR_RD: begin
          if (rd_ptr_q[5]) state_q <= CLR_FILL;
          else if (grid_gnt_i) state_q <= CLR_WAIT;
        end
        CLR_WAIT: if (rd_back) begin
          if (row_full) begin
            found_q  <= found_q + 3'd1; // drop it
            rd_ptr_q <= rd_ptr_q - 6'sd1;
            state_q  <= CLR_RD;
          end else if (rd_ptr_q != wr_ptr_q) state_q <= CLR_WR;
          else begin
            rd_ptr_q <= rd_ptr_q - 6'sd1; // already in place
            wr_ptr_q <= wr_ptr_q - 6'sd1;
            state_q  <= CLR_RD;
          end
        end
        CLR_WR: if (grid_gnt_i) begin
          rd_ptr_q <= rd_ptr_q - 6'sd1;
          wr_ptr_q <= wr_ptr_q - 6'sd1;
          state_q  <= CLR_RD;
        end
        default: begin // CLR_FILL
          if (wr_ptr_q[5]) begin
            done_o  <= 1'b1;
            lines_o <= found_q;
            state_q <= CLR_IDLE;
          end else if (grid_gnt_i) wr_ptr_q <= wr_ptr_q - 6'sd1;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == CLR_WAIT && rd_back) row_q <= grid_rsp_i.rdata;
  end

endmodule

`default_nettype wire

/* design/apb_host_port.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_host_port #(
  parameter int ROWS = 16
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  logic [7:0]               paddr_i,
  input  logic [31:0]              pwdata_i,
  output logic [31:0]              prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  output logic                     cmd_valid_o,
  output blockfall_pkg::cmd_t      cmd_o,
  input  logic                     busy_i,
  input  logic                     last_ok_i,
  input  logic                     game_over_i,
  input  blockfall_pkg::piece_t    piece_i,
  input  logic                     lines_valid_i,
  input  logic [2:0]               lines_i,
  output blockfall_pkg::grid_req_t grid_req_o,
  input  logic                     grid_gnt_i,
  input  blockfall_pkg::grid_rsp_t grid_rsp_i
);
  import blockfall_pkg::*;

  typedef enum logic [1:0] {RD_IDLE, RD_WAIT, RD_DONE} rd_state_e;

  rd_state_e  rd_state_q;
  logic       access, sel_cmd, sel_status, sel_piece, sel_row, row_rd, err;
  logic [3:0] row_idx;
  logic [7:0] lines_cnt_q;
  row_t       row_q;

  assign access     = psel_i && penable_i;
  assign row_idx    = paddr_i[5:2];
  assign sel_cmd    = (paddr_i == 8'h00);
  assign sel_status = (paddr_i == 8'h04);
  assign sel_piece  = (paddr_i == 8'h08);
  assign sel_row    = (paddr_i[7:6] == 2'b01) && (paddr_i[1:0] == 2'b00) &&
                      (int'(row_idx) < ROWS);

  // unmapped, read-only written, or cmd while busy
  assign err = !(sel_cmd || sel_status || sel_piece || sel_row) ||
               (pwrite_i && !sel_cmd) || (pwrite_i && sel_cmd && busy_i);

  assign row_rd      = access && !pwrite_i && sel_row;
  assign pready_o    = access && (!row_rd || rd_state_q == RD_DONE);
  assign pslverr_o   = pready_o && err;
  assign cmd_valid_o = access && pwrite_i && sel_cmd && !busy_i;
  assign cmd_o       = cmd_t'(pwdata_i[4:0]);

  always_comb begin
    grid_req_o      = '0;
    grid_req_o.req  = row_rd && rd_state_q != RD_DONE; // held to keep the grant
    grid_req_o.addr = {1'b0, row_idx};
  end

  always_comb begin
    prdata_o = '0;
    if (sel_status) prdata_o = {16'd0, lines_cnt_q, 5'd0, game_over_i, last_ok_i, busy_i};
    else if (sel_piece) prdata_o[13:0] = piece_i;
    else if (sel_row) prdata_o[23:0] = row_q;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_state_q  <= RD_IDLE;
      lines_cnt_q <= '0;
    end else begin
      if (lines_valid_i) lines_cnt_q <= lines_cnt_q + 8'(lines_i);
      case (rd_state_q)
        RD_IDLE: if (row_rd && grid_gnt_i) rd_state_q <= RD_WAIT;
        RD_WAIT: if (grid_gnt_i && grid_rsp_i.rvalid) rd_state_q <= RD_DONE;
        default: rd_state_q <= RD_IDLE; // pready went out this cycle
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_state_q == RD_WAIT && grid_gnt_i && grid_rsp_i.rvalid) row_q <= grid_rsp_i.rdata;
  end

endmodule

`default_nettype wire

/* design/blockfall_top.sv */
`timescale 1ns/100ps
`default_nettype none

module blockfall_top #(
  parameter int ROWS = 16
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [7:0]  paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o
);
  import blockfall_pkg::*;

  grid_req_t  clr_req, trk_req, host_req, mem_req;
  grid_rsp_t  mem_rsp;     // shared by all three peers
  logic       clr_gnt, trk_gnt, host_gnt, mem_ready;
  logic       cmd_valid, busy, last_ok, game_over;
  logic       clear_start, clear_done;
  logic [2:0] lines;
  cmd_t       cmd;
  piece_t     piece;

  //////////////////////////////
  // board memory and its arbiter

  grid_ram #(.ROWS(ROWS)) u_ram (
    .clk_i(clk_i), .reset_i(reset_i),
    .req_i(mem_req), .rsp_o(mem_rsp), .ready_o(mem_ready)
  );

  grid_arbiter u_arb (
    .clk_i(clk_i), .reset_i(reset_i),
    .clr_req_i(clr_req), .trk_req_i(trk_req), .host_req_i(host_req),
    .clr_gnt_o(clr_gnt), .trk_gnt_o(trk_gnt), .host_gnt_o(host_gnt),
    .mem_req_o(mem_req), .mem_ready_i(mem_ready)
  );

  //////////////////////////////
  // peers

  piece_tracker #(.ROWS(ROWS)) u_tracker (
    .clk_i(clk_i), .reset_i(reset_i),
    .cmd_valid_i(cmd_valid), .cmd_i(cmd),
    .busy_o(busy), .last_ok_o(last_ok), .game_over_o(game_over), .piece_o(piece),
    .grid_req_o(trk_req), .grid_gnt_i(trk_gnt), .grid_rsp_i(mem_rsp),
    .clear_start_o(clear_start), .clear_done_i(clear_done)
  );

  line_clearer #(.ROWS(ROWS)) u_clearer (
    .clk_i(clk_i), .reset_i(reset_i), .start_i(clear_start),
    .grid_req_o(clr_req), .grid_gnt_i(clr_gnt), .grid_rsp_i(mem_rsp),
    .done_o(clear_done), .lines_o(lines)
  );

  apb_host_port #(.ROWS(ROWS)) u_host (
    .clk_i(clk_i), .reset_i(reset_i),
    .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i),
    .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
    .cmd_valid_o(cmd_valid), .cmd_o(cmd),
    .busy_i(busy), .last_ok_i(last_ok), .game_over_i(game_over), .piece_i(piece),
    .lines_valid_i(clear_done), .lines_i(lines),
    .grid_req_o(host_req), .grid_gnt_i(host_gnt), .grid_rsp_i(mem_rsp)
  );

endmodule

`default_nettype wire

/* bench/blockfall_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module blockfall_assert (
  input logic       clk_i,
  input logic       reset_i,
  input logic [2:0] gnt_i,     // clearer, tracker, host
  input logic [2:0] req_i,
  input logic       pready_i,
  input logic       pslverr_i
);

  // never two owners of the ram port
  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt_i))
    else $error("more than one ram grant at once");

  // owner keeps its grant while req stays up
  assert property (@(posedge clk_i) disable iff (reset_i)
    (req_i & $past(gnt_i & req_i) & ~gnt_i) == 3'b000)
    else $error("ram grant taken from an owner that still requests");

  assert property (@(posedge clk_i) disable iff (reset_i) pslverr_i |-> pready_i)
    else $error("pslverr outside of a completing transfer");

endmodule

//////////////////////////////
// attach to the arbiter and the apb port

bind grid_arbiter blockfall_assert u_arb_chk (
  .clk_i(clk_i), .reset_i(reset_i),
  .gnt_i({clr_gnt_o, trk_gnt_o, host_gnt_o}),
  .req_i({clr_req_i.req, trk_req_i.req, host_req_i.req}),
  .pready_i(1'b1), .pslverr_i(1'b0)
);

bind apb_host_port blockfall_assert u_apb_chk (
  .clk_i(clk_i), .reset_i(reset_i),
  .gnt_i(3'b000), .req_i(3'b000),
  .pready_i(pready_o), .pslverr_i(pslverr_o)
);

`default_nettype wire

/* bench/blockfall_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module blockfall_tb;
  import blockfall_pkg::*;

  localparam int ROWS = 16;

  typedef struct {
    move_e  op;
    piece_e kind;    // spawn kind and expected kind
    int     reps;
    int     ok;
    int     valid;
    int     rot;
    int     x;
    int     y;
    int     lines;
    int     rows;    // read back the board afterwards
  } entry_t;

  logic        clk, reset, psel, penable, pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata, prdata;
  logic        pready, pslverr;

  int     board [ROWS][COLS];   // model of the board
  int     m_valid, m_kind, m_rot, m_x, m_y, m_over, m_lines;
  int     errors, test_errors, tests, cycles, limit;
  entry_t tbl [$];

  blockfall_top #(.ROWS(ROWS)) DUT (
    .clk_i(clk), .reset_i(reset),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata),
    .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////
  // board model

  // offsets as {x0,y0,x1,y1,x2,y2,x3,y3}
  function automatic logic [15:0] shape_code(int kind, int rot);
    if (kind == 0) return {2'd1, 2'd0, 2'd2, 2'd0, 2'd1, 2'd1, 2'd2, 2'd1};
    if (kind == 1) begin
      if (rot % 2 == 1) return {2'd2, 2'd0, 2'd2, 2'd1, 2'd2, 2'd2, 2'd2, 2'd3};
      return {2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1, 2'd3, 2'd1};
    end
    case (rot)
      0:       return {2'd1, 2'd0, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1};
      1:       return {2'd1, 2'd0, 2'd1, 2'd1, 2'd2, 2'd1, 2'd1, 2'd2};
      2:       return {2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1, 2'd1, 2'd2};
      default: return {2'd1, 2'd0, 2'd0, 2'd1, 2'd1, 2'd1, 2'd1, 2'd2};
    endcase
  endfunction

  function automatic bit fits(int kind, int rot, int x, int y);
    logic [15:0] code;
    int          cx, cy;
    code = shape_code(kind, rot);
    for (int i = 0; i < 4; i++) begin
      cx = x + int'(code[15-4*i -: 2]);
      cy = y + int'(code[13-4*i -: 2]);
      if (cx < 0 || cx >= COLS || cy < 0 || cy >= ROWS) return 1'b0;
      if (board[cy][cx] != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic lock_piece();
    logic [15:0] code;
    int          newb [ROWS][COLS];
    int          w, full;
    code = shape_code(m_kind, m_rot);
    for (int i = 0; i < 4; i++)
      board[m_y + int'(code[13-4*i -: 2])][m_x + int'(code[15-4*i -: 2])] = m_kind + 1;
    m_valid = 0;
    for (int r = 0; r < ROWS; r++)
      for (int c = 0; c < COLS; c++) newb[r][c] = 0;
    w = ROWS - 1;
    for (int r = ROWS - 1; r >= 0; r--) begin
      full = 1;
      for (int c = 0; c < COLS; c++) if (board[r][c] == 0) full = 0;
      if (full != 0) m_lines++; // row drops out
      else begin
        newb[w] = board[r];
        w--;
      end
    end
    board = newb;
  endtask

  task automatic model_cmd(input move_e op, input piece_e kind, output bit ok);
    int nr, nx, ny;
    ok = 1'b0;
    if (m_over != 0) return;
    if (op == MOVE_SPAWN) begin
      if (m_valid != 0) return;
      if (fits(int'(kind), 0, 2, 0)) begin
        m_valid = 1;
        m_kind  = int'(kind);
        m_rot   = 0;
        m_x     = 2;
        m_y     = 0;
        ok      = 1'b1;
      end else m_over = 1;
      return;
    end
    if (m_valid == 0) return;
    nr = m_rot;
    nx = m_x;
    ny = m_y;
    case (op)
      MOVE_LEFT:  nx--;
      MOVE_RIGHT: nx++;
      MOVE_ROR:   nr = (nr + 1) % 4;
      MOVE_ROL:   nr = (nr + 3) % 4;
      MOVE_DOWN:  ny++;
      default:    return;
    endcase
    if (fits(m_kind, nr, nx, ny)) begin
      m_rot = nr;
      m_x   = nx;
      m_y   = ny;
      ok    = 1'b1;
    end else if (op == MOVE_DOWN) lock_piece(); // landed
  endtask

  //////////////////////////////
  // apb and check helpers

  task automatic apb_access(input bit wr, input logic [7:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output bit err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) @(negedge clk); // row reads stall here
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic check_value(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    errors += test_errors;
    if (test_errors == 0) $display("%s: ok", name);
    else $display("%s: %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    bit          e;
    st = 32'd1;
    while (st[0]) apb_access(1'b0, 8'h04, 32'd0, st, e);
  endtask

  task automatic run_cmd(input move_e op, input piece_e kind, output bit mok);
    logic [31:0] d;
    bit          err;
    apb_access(1'b1, 8'h00, {27'd0, kind, op}, d, err);
    if (err) begin
      $display("command write at %0t was refused by the bus", $time);
      test_errors++;
    end
    wait_idle();
    model_cmd(op, kind, mok);
  endtask

  task automatic check_status(input int ok, input int over, input int lines);
    logic [31:0] d;
    bit          e;
    apb_access(1'b0, 8'h04, 32'd0, d, e);
    check_value("last_ok", int'(d[1]), ok);
    check_value("game_over", int'(d[2]), over);
    check_value("lines cleared", int'(d[15:8]), lines);
  endtask

  task automatic check_piece(input int v, input int k, input int rot, input int x, input int y);
    logic [31:0] d;
    bit          e;
    apb_access(1'b0, 8'h08, 32'd0, d, e);
    check_value("piece valid", int'(d[13]), v);
    check_value("piece kind", int'(d[12:11]), k);
    check_value("piece rot", int'(d[10:9]), rot);
    check_value("piece x", int'($signed(d[8:5])), x);
    check_value("piece y", int'($signed(d[4:0])), y);
  endtask

  task automatic check_rows();
    logic [31:0] d;
    logic [23:0] exp;
    bit          e;
    for (int r = 0; r < ROWS; r++) begin
      apb_access(1'b0, 8'(64 + 4 * r), 32'd0, d, e);
      for (int c = 0; c < COLS; c++) exp[3*c +: 3] = 3'(board[r][c]);
      check_value($sformatf("row %0d", r), int'(d[23:0]), int'(exp));
    end
  endtask

  task automatic add_entry(input move_e op, input piece_e kind, input int reps, input int ok,
                           input int valid, input int rot, input int x, input int y,
                           input int lines, input int rows);
    entry_t en;
    en.op    = op;
    en.kind  = kind;
    en.reps  = reps;
    en.ok    = ok;
    en.valid = valid;
    en.rot   = rot;
    en.x     = x;
    en.y     = y;
    en.lines = lines;
    en.rows  = rows;
    tbl.push_back(en);
  endtask

  //////////////////////////////
  // main sequence

  initial begin
    entry_t      en;
    logic [31:0] d;
    bit          err, mok;
    int          extra, pieces;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    reset   = 1'b1;
    limit   = 0;
    void'($urandom(39));
    for (int r = 0; r < ROWS; r++)
      for (int c = 0; c < COLS; c++) board[r][c] = 0;
    m_valid = 0;
    m_over  = 0;
    m_lines = 0;

    // op, kind, reps, ok, valid, rot, x, y, lines, rows
    add_entry(MOVE_SPAWN, PIECE_I,  1, 1, 1, 0, 2,  0, 0, 0);
    add_entry(MOVE_LEFT,  PIECE_I,  2, 1, 1, 0, 0,  0, 0, 0);
    add_entry(MOVE_LEFT,  PIECE_I,  1, 0, 1, 0, 0,  0, 0, 0); // past column 0
    add_entry(MOVE_DOWN,  PIECE_I, 14, 1, 1, 0, 0, 14, 0, 0);
    add_entry(MOVE_DOWN,  PIECE_I,  1, 0, 0, 0, 0, 14, 0, 1); // lock on the floor
    add_entry(MOVE_SPAWN, PIECE_T,  1, 1, 1, 0, 2,  0, 0, 0);
    add_entry(MOVE_ROR,   PIECE_T,  1, 1, 1, 1, 2,  0, 0, 0);
    add_entry(MOVE_ROR,   PIECE_T,  1, 1, 1, 2, 2,  0, 0, 0);
    add_entry(MOVE_ROL,   PIECE_T,  1, 1, 1, 1, 2,  0, 0, 0);
    add_entry(MOVE_ROL,   PIECE_T,  1, 1, 1, 0, 2,  0, 0, 0);
    add_entry(MOVE_RIGHT, PIECE_T,  3, 1, 1, 0, 5,  0, 0, 0);
    add_entry(MOVE_RIGHT, PIECE_T,  1, 0, 1, 0, 5,  0, 0, 0); // right edge
    add_entry(MOVE_LEFT,  PIECE_T,  5, 1, 1, 0, 0,  0, 0, 0);
    add_entry(MOVE_LEFT,  PIECE_T,  1, 0, 1, 0, 0,  0, 0, 0);
    add_entry(MOVE_DOWN,  PIECE_T, 13, 1, 1, 0, 0, 13, 0, 0);
    add_entry(MOVE_DOWN,  PIECE_T,  1, 0, 0, 0, 0, 13, 0, 1); // rests on the I
    add_entry(MOVE_SPAWN, PIECE_I,  1, 1, 1, 0, 2,  0, 0, 0);
    add_entry(MOVE_RIGHT, PIECE_I,  2, 1, 1, 0, 4,  0, 0, 0);
    add_entry(MOVE_RIGHT, PIECE_I,  1, 0, 1, 0, 4,  0, 0, 0);
    add_entry(MOVE_DOWN,  PIECE_I, 14, 1, 1, 0, 4, 14, 0, 0);
    add_entry(MOVE_DOWN,  PIECE_I,  1, 0, 0, 0, 4, 14, 1, 1); // bottom row clears

    limit = tbl.size() * 300 + 2000;

    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    foreach (tbl[i]) begin
      en = tbl[i];
      for (int k = 0; k < en.reps; k++) run_cmd(en.op, en.kind, mok);
      check_status(en.ok, 0, en.lines);
      check_piece(en.valid, int'(en.kind), en.rot, en.x, en.y);
      if (en.rows != 0) check_rows();
      report_test($sformatf("table entry %0d", i));
    end

    // bus errors and moves with no piece
    run_cmd(MOVE_LEFT, PIECE_O, mok);
    check_status(0, 0, 1);
    check_piece(0, 1, 0, 4, 14);
    apb_access(1'b0, 8'h0C, 32'd0, d, err);
    check_value("pslverr on unmapped read", int'(err), 1);
    apb_access(1'b1, 8'h04, 32'hFFFF_FFFF, d, err);
    check_value("pslverr on status write", int'(err), 1);
    apb_access(1'b0, 8'h80, 32'd0, d, err);
    check_value("pslverr on row past the board", int'(err), 1);
    apb_access(1'b1, 8'h40, 32'h00FF_FFFF, d, err);
    check_value("pslverr on row write", int'(err), 1);
    apb_access(1'b1, 8'h00, {27'd0, PIECE_O, MOVE_SPAWN}, d, err);
    check_value("pslverr on accepted cmd", int'(err), 0);
    model_cmd(MOVE_SPAWN, PIECE_O, mok);
    apb_access(1'b1, 8'h00, {27'd0, PIECE_T, MOVE_SPAWN}, d, err); // tracker still busy
    check_value("pslverr on cmd while busy", int'(err), 1);
    wait_idle();
    check_status(1, 0, 1);
    check_piece(1, 0, 0, 2, 0);
    check_rows();
    report_test("bus errors");

    // stack O pieces in one column until a spawn collides
    pieces = 0;
    while (m_over == 0 && pieces < 12) begin
      mok = 1'b1;
      while (mok) begin
        run_cmd(MOVE_DOWN, PIECE_O, mok);
        check_status(int'(mok), m_over, m_lines);
      end
      extra = $urandom_range(0, 2);
      repeat (extra) begin
        run_cmd(MOVE_DOWN, PIECE_O, mok);
        check_status(0, m_over, m_lines);
      end
      run_cmd(MOVE_SPAWN, PIECE_O, mok);
      check_status(int'(mok), m_over, m_lines);
      pieces++;
    end
    run_cmd(MOVE_LEFT, PIECE_O, mok);
    check_status(0, 1, m_lines);
    run_cmd(MOVE_SPAWN, PIECE_T, mok);
    check_status(0, 1, m_lines);
    check_piece(m_valid, m_kind, m_rot, m_x, m_y);
    check_rows();
    report_test("stack to game over");

    $display("%0d tests, %0d errors", tests, errors);
    if (errors == 0) $display("Test passed");
    else $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* blockfall.f */
design/blockfall_pkg.sv
design/grid_ram.sv
design/grid_arbiter.sv
design/piece_tracker.sv
design/line_clearer.sv
design/apb_host_port.sv
design/blockfall_top.sv
bench/blockfall_assert.sv
bench/blockfall_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator and run; success only if the pass line shows up
verilator --binary --timing --assert --top-module blockfall_tb -f blockfall.f -o blockfall_sim \
  && ./obj_dir/blockfall_sim | tee /dev/stderr | grep -q "^Test passed$" \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }
